//--- source/pq_pkg.sv
// --------------------------------------------------
// Shared widths, slot count and entry types for the
// four-slot request queue. NUM_SLOTS is tied to the
// two-level ranking tree and must stay at four.
// --------------------------------------------------
package pq_pkg;

    localparam int ZONE_W    = 8;
    localparam int PRI_W     = 2;
    localparam int WAIT_W    = 8;
    localparam int NUM_SLOTS = 4;
    localparam int IDX_W     = 2;

    // Request as it arrives on the insert port
    typedef struct packed {
        logic [ZONE_W-1:0] zone;
        logic [PRI_W-1:0]  pri;
    } pq_req_t;

    // Slot contents as seen by control and arbiter
    typedef struct packed {
        logic [ZONE_W-1:0] zone;
        logic [PRI_W-1:0]  pri;
        logic [WAIT_W-1:0] wait_cnt;
        logic              boost;
        logic              valid;
    } pq_entry_t;

    // Head of queue as handed to the consumer
    typedef struct packed {
        logic [ZONE_W-1:0] zone;
        logic [PRI_W-1:0]  pri;
        logic              boost;
    } pq_grant_t;

    // True when a outranks b. Callers pass the lower slot first,
    // so a full tie resolves to the lower index
    function automatic logic rank_first(input pq_entry_t a, input pq_entry_t b);
        if (!a.valid || !b.valid)
            return a.valid || !b.valid;
        if (a.boost != b.boost)
            return a.boost;
        if (a.pri != b.pri)
            return a.pri > b.pri;
        if (a.wait_cnt != b.wait_cnt)
            return a.wait_cnt > b.wait_cnt;
        return 1'b1;
    endfunction

endpackage

//--- source/request_slot.sv
`timescale 1ns/10ps
// --------------------------------------------------
// One queue slot. Clear wins over write, write wins
// over hold. Wait count saturates at all ones and the
// boost flag stays set until the slot is cleared.
// --------------------------------------------------
module request_slot
    import pq_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              write_en,
    input  logic              clear,
    input  pq_req_t           req,
    input  logic [WAIT_W-1:0] threshold,
    output pq_entry_t         entry
);

    pq_req_t           req_q;
    logic [WAIT_W-1:0] wait_q;
    logic              boost_q;
    logic              valid_q;

    // Zone and priority only change on an accepted write
    always_ff @(posedge clk) begin
        if (write_en && !clear) begin
            req_q <= req;
        end
    end

    // --------------------------------------------------
    // Valid, aging and boost
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            boost_q <= 1'b0;
            wait_q  <= '0;
        end else if (clear) begin
            valid_q <= 1'b0;
            boost_q <= 1'b0;
            wait_q  <= '0;
        end else if (write_en) begin
            valid_q <= 1'b1;
            boost_q <= 1'b0;
            wait_q  <= '0;
        end else if (valid_q) begin
            // Boost looks at the count before this cycle's increment
            if (wait_q >= threshold) begin
                boost_q <= 1'b1;
            end
            if (wait_q != '1) begin
                wait_q <= wait_q + 1'b1;
            end
        end
    end

    assign entry = '{zone: req_q.zone, pri: req_q.pri, wait_cnt: wait_q,
                     boost: boost_q, valid: valid_q};

    // A fresh request starts unaged and unboosted
    a_write_fresh: assert property (@(posedge clk) disable iff (!rst_n)
        write_en && !clear |=> entry.valid && entry.wait_cnt == '0 && !entry.boost);

endmodule

//--- source/slot_arbiter.sv
`timescale 1ns/10ps
// --------------------------------------------------
// Two-level ranking tree over the four slots. Purely
// combinational. head.valid is low only when every
// slot is empty, and head_idx is then zero.
// --------------------------------------------------
module slot_arbiter
    import pq_pkg::*;
(
    input  pq_entry_t        entries [NUM_SLOTS],
    output pq_entry_t        head,
    output logic [IDX_W-1:0] head_idx
);

    logic             sel_01;
    logic             sel_23;
    logic             sel_fin;
    pq_entry_t        win_01;
    pq_entry_t        win_23;
    logic [IDX_W-1:0] idx_01;
    logic [IDX_W-1:0] idx_23;

    // --------------------------------------------------
    // First level
    // --------------------------------------------------
    // Slot 0 against slot 1
    assign sel_01 = rank_first(entries[0], entries[1]);
    assign win_01 = sel_01 ? entries[0] : entries[1];
    assign idx_01 = sel_01 ? IDX_W'(0) : IDX_W'(1);

    // Slot 2 against slot 3
    assign sel_23 = rank_first(entries[2], entries[3]);
    assign win_23 = sel_23 ? entries[2] : entries[3];
    assign idx_23 = sel_23 ? IDX_W'(2) : IDX_W'(3);

    // --------------------------------------------------
    // Final level
    // --------------------------------------------------
    // Lower pair goes first so equal entries favour the lower index
    assign sel_fin  = rank_first(win_01, win_23);
    assign head     = sel_fin ? win_01 : win_23;
    assign head_idx = sel_fin ? idx_01 : idx_23;

    // Index tracking must agree with the entry that won
    always_comb begin
        if (head.valid) begin
            a_head_idx_valid: assert (entries[head_idx].valid)
            else $error("head_idx %0d points at an empty slot", head_idx);
        end
    end

endmodule

//--- source/queue_ctrl.sv
`timescale 1ns/10ps
// --------------------------------------------------
// Slot allocation and clearing. An insert goes to the
// lowest free slot. serve_fire must only be raised
// while the head entry is valid.
// --------------------------------------------------
module queue_ctrl
    import pq_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  pq_entry_t            entries [NUM_SLOTS],
    input  logic                 insert_valid,
    output logic                 insert_ready,
    input  logic                 cancel_en,
    input  logic [ZONE_W-1:0]    cancel_zone,
    input  logic                 serve_fire,
    input  logic [IDX_W-1:0]     head_idx,
    output logic [NUM_SLOTS-1:0] write_en,
    output logic [NUM_SLOTS-1:0] clear
);

    logic [IDX_W-1:0]     free_idx;
    logic [NUM_SLOTS-1:0] cancel_hit;

    // --------------------------------------------------
    // Free slot search
    // --------------------------------------------------
    // Walk downwards so the lowest free slot is the last one kept
    always_comb begin
        insert_ready = 1'b0;
        free_idx     = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                insert_ready = 1'b1;
                free_idx     = IDX_W'(i);
            end
        end
    end

    always_comb begin
        write_en = '0;
        if (insert_valid && insert_ready) begin
            write_en[free_idx] = 1'b1;
        end
    end

    // --------------------------------------------------
    // Serve and cancel clearing
    // --------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            cancel_hit[i] = cancel_en && entries[i].valid
                            && (entries[i].zone == cancel_zone);
            clear[i]      = cancel_hit[i] || (serve_fire && head_idx == IDX_W'(i));
        end
    end

    a_write_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(write_en));

    // Writes land on free slots, clears on occupied ones
    a_write_clear_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
        (write_en & clear) == '0);

endmodule

//--- source/pq_top.sv
`timescale 1ns/10ps
// --------------------------------------------------
// Four-slot request queue with aging and boost.
// out_valid and out_grant are combinational from the
// slot registers. threshold is expected to be static.
// A full queue refuses inserts even while serving.
// --------------------------------------------------
module pq_top
    import pq_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              insert_valid,
    output logic              insert_ready,
    input  pq_req_t           insert_req,
    input  logic [WAIT_W-1:0] threshold,
    input  logic              cancel_en,
    input  logic [ZONE_W-1:0] cancel_zone,
    output logic              out_valid,
    input  logic              out_ready,
    output pq_grant_t         out_grant
);

    pq_entry_t            entries [NUM_SLOTS];
    pq_entry_t            head;
    logic [IDX_W-1:0]     head_idx;
    logic [NUM_SLOTS-1:0] write_en;
    logic [NUM_SLOTS-1:0] clear;
    logic                 serve_fire;

    // Serve handshake on the head of queue
    assign serve_fire = out_valid && out_ready;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    queue_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .entries      (entries),
        .insert_valid (insert_valid),
        .insert_ready (insert_ready),
        .cancel_en    (cancel_en),
        .cancel_zone  (cancel_zone),
        .serve_fire   (serve_fire),
        .head_idx     (head_idx),
        .write_en     (write_en),
        .clear        (clear)
    );

    // --------------------------------------------------
    // Slots
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        request_slot u_slot (
            .clk       (clk),
            .rst_n     (rst_n),
            .write_en  (write_en[i]),
            .clear     (clear[i]),
            .req       (insert_req),
            .threshold (threshold),
            .entry     (entries[i])
        );
    end

    // Head selection
    slot_arbiter u_arb (
        .entries  (entries),
        .head     (head),
        .head_idx (head_idx)
    );

    assign out_valid = head.valid;
    assign out_grant = '{zone: head.zone, pri: head.pri, boost: head.boost};

endmodule

//--- verif/pq_ref_model.svh
// --------------------------------------------------
// Cycle model of the four queue slots. Included in
// the testbench module and reads its DUT input nets.
// Ranking uses a key of boost, priority and wait, and
// a scan from slot 0 keeps the lower index on ties.
// --------------------------------------------------
`ifndef PQ_REF_MODEL_SVH
`define PQ_REF_MODEL_SVH

logic [ZONE_W-1:0] ref_zone  [NUM_SLOTS];
logic [PRI_W-1:0]  ref_pri   [NUM_SLOTS];
logic [WAIT_W-1:0] ref_wait  [NUM_SLOTS];
logic              ref_boost [NUM_SLOTS];
logic              ref_valid [NUM_SLOTS];

task automatic reset_model();
    for (int i = 0; i < NUM_SLOTS; i++) begin
        ref_zone[i]  = '0;
        ref_pri[i]   = '0;
        ref_wait[i]  = '0;
        ref_boost[i] = 1'b0;
        ref_valid[i] = 1'b0;
    end
endtask

// Boost above priority above wait time
function automatic logic [WAIT_W+PRI_W:0] rank_key(input int i);
    return {ref_boost[i], ref_pri[i], ref_wait[i]};
endfunction

// Expected head slot, -1 when the queue is empty
function automatic int best_slot();
    int best;
    best = -1;
    for (int i = 0; i < NUM_SLOTS; i++) begin
        if (ref_valid[i]) begin
            if (best < 0 || rank_key(i) > rank_key(best)) begin
                best = i;
            end
        end
    end
    return best;
endfunction

// Slot the next insert goes to, -1 when full
function automatic int lowest_free();
    for (int i = 0; i < NUM_SLOTS; i++) begin
        if (!ref_valid[i]) begin
            return i;
        end
    end
    return -1;
endfunction

// Apply the coming clock edge with the inputs now on the DUT
task automatic advance_model();
    int   head_slot;
    int   free_slot;
    logic fire;
    logic accept;
    logic hit;
    head_slot = best_slot();
    free_slot = lowest_free();
    fire      = (head_slot >= 0) && out_ready;
    accept    = insert_valid && (free_slot >= 0);
    for (int i = 0; i < NUM_SLOTS; i++) begin
        hit = cancel_en && ref_valid[i] && (ref_zone[i] == cancel_zone);
        if (hit || (fire && i == head_slot)) begin
            ref_valid[i] = 1'b0;
            ref_boost[i] = 1'b0;
            ref_wait[i]  = '0;
        end else if (accept && i == free_slot) begin
            ref_valid[i] = 1'b1;
            ref_zone[i]  = insert_req.zone;
            ref_pri[i]   = insert_req.pri;
            ref_boost[i] = 1'b0;
            ref_wait[i]  = '0;
        end else if (ref_valid[i]) begin
            if (ref_wait[i] >= threshold) begin
                ref_boost[i] = 1'b1;
            end
            if (ref_wait[i] != {WAIT_W{1'b1}}) begin
                ref_wait[i] = ref_wait[i] + WAIT_W'(1);
            end
        end
    end
endtask

`endif

//--- verif/tb_pq_top.sv
`timescale 1ns/10ps
// --------------------------------------------------
// Testbench for the four-slot request queue. Inputs
// change 2 ns after the rising edge, outputs are
// compared 2 ns before it. Stops at the first error.
// --------------------------------------------------
module tb_pq_top
    import pq_pkg::*;
();

    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 600;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              insert_valid;
    logic              insert_ready;
    pq_req_t           insert_req;
    logic [WAIT_W-1:0] threshold;
    logic              cancel_en;
    logic [ZONE_W-1:0] cancel_zone;
    logic              out_valid;
    logic              out_ready;
    pq_grant_t         out_grant;
    int                errors;

    `include "pq_ref_model.svh"

    pq_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .insert_valid (insert_valid),
        .insert_ready (insert_ready),
        .insert_req   (insert_req),
        .threshold    (threshold),
        .cancel_en    (cancel_en),
        .cancel_zone  (cancel_zone),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_grant    (out_grant)
    );

    always #10 clk = ~clk;

    // --------------------------------------------------
    // Checking helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping on failure");
    endtask

    task automatic compare_outputs();
        int        head_slot;
        pq_grant_t exp_grant;
        head_slot = best_slot();
        check_value("insert_ready", insert_ready, lowest_free() >= 0);
        check_value("out_valid", out_valid, head_slot >= 0);
        // Grant is only defined while the head is valid
        if (head_slot >= 0) begin
            exp_grant = '{zone: ref_zone[head_slot], pri: ref_pri[head_slot],
                          boost: ref_boost[head_slot]};
            check_value("out_grant", out_grant, exp_grant);
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic apply_inputs(input logic ins_v, input pq_req_t req, input logic can_en,
                                input logic [ZONE_W-1:0] can_zone, input logic o_ready);
        @(posedge clk);
        #2;
        insert_valid = ins_v;
        insert_req   = req;
        cancel_en    = can_en;
        cancel_zone  = can_zone;
        out_ready    = o_ready;
    endtask

    task automatic idle();
        apply_inputs(1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    // Holds the request until the queue has room
    task automatic insert_request(input logic [ZONE_W-1:0] zone, input logic [PRI_W-1:0] pri);
        int tries;
        tries = 0;
        apply_inputs(1'b1, '{zone: zone, pri: pri}, 1'b0, '0, 1'b0);
        while (!insert_ready) begin
            tries++;
            if (tries > 20) begin
                report_failure("insert was never accepted by the queue");
            end
            apply_inputs(1'b1, '{zone: zone, pri: pri}, 1'b0, '0, 1'b0);
        end
    endtask

    task automatic serve_one();
        int tries;
        tries = 0;
        apply_inputs(1'b0, '0, 1'b0, '0, 1'b1);
        while (!out_valid) begin
            tries++;
            if (tries > 20) begin
                report_failure("queue never offered an entry to serve");
            end
            apply_inputs(1'b0, '0, 1'b0, '0, 1'b1);
        end
    endtask

    task automatic drain_queue();
        int tries;
        tries = 0;
        apply_inputs(1'b0, '0, 1'b0, '0, 1'b1);
        while (out_valid) begin
            tries++;
            if (tries > 2 * NUM_SLOTS) begin
                report_failure("queue did not drain");
            end
            apply_inputs(1'b0, '0, 1'b0, '0, 1'b1);
        end
        idle();
    endtask

    // --------------------------------------------------
    // Compare process and watchdog
    // --------------------------------------------------
    initial begin
        reset_model();
        wait (rst_n);
        forever begin
            @(posedge clk);
            #18;
            compare_outputs();
            advance_model();
        end
    end

    initial begin
        #(TOTAL_CYCLES * 20 + 2000);
        $display("timeout: the tests did not finish in the expected time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        pq_req_t rnd_req;
        void'($urandom(32'h99bb));
        errors       = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        insert_valid = 1'b0;
        insert_req   = '0;
        threshold    = 8'hff;
        cancel_en    = 1'b0;
        cancel_zone  = '0;
        out_ready    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("insert_ready", insert_ready, 1);
        check_value("out_valid", out_valid, 0);

        // Full queue refuses a fifth request
        for (int i = 0; i < NUM_SLOTS; i++) begin
            insert_request(ZONE_W'(i + 1), PRI_W'($urandom_range(0, 3)));
        end
        idle();
        check_value("insert_ready", insert_ready, 0);
        repeat (3) begin
            apply_inputs(1'b1, '{zone: 8'hee, pri: 2'd3}, 1'b0, '0, 1'b0);
            check_value("insert_ready", insert_ready, 0);
        end
        for (int i = 0; i < NUM_SLOTS; i++) begin
            serve_one();
            idle();
        end
        check_value("out_valid", out_valid, 0);

        // Priority, then age order with no boost
        threshold = 8'hff;
        repeat (3) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                insert_request(ZONE_W'(16 + i), PRI_W'($urandom_range(0, 3)));
                repeat ($urandom_range(0, 2)) idle();
            end
            for (int i = 0; i < NUM_SLOTS; i++) begin
                serve_one();
                idle();
            end
        end
        drain_queue();

        // Saturated waits tie, lower slot index wins
        insert_request(8'h50, 2'd2);
        insert_request(8'h51, 2'd2);
        idle();
        apply_inputs(1'b0, '0, 1'b1, 8'h50, 1'b0);
        idle();
        // Younger entry refills slot 0 below the older one
        insert_request(8'h52, 2'd2);
        repeat (270) idle();
        check_value("out_grant.zone", out_grant.zone, 8'h52);
        drain_queue();

        // Aged priority 0 entry overtakes fresh priority 3 ones
        threshold = 8'd3;
        insert_request(8'h40, 2'd0);
        repeat (5) idle();
        insert_request(8'h41, 2'd3);
        insert_request(8'h42, 2'd3);
        idle();
        check_value("out_grant", out_grant, {8'h40, 2'd0, 1'b1});
        serve_one();
        drain_queue();

        // Cancel by zone
        threshold = 8'hff;
        insert_request(8'h05, 2'd3);
        insert_request(8'h09, 2'd1);
        insert_request(8'h05, 2'd2);
        insert_request(8'h07, 2'd1);
        idle();
        apply_inputs(1'b0, '0, 1'b1, 8'h05, 1'b0);
        idle();
        check_value("out_grant.zone", out_grant.zone, 8'h09);
        serve_one();
        idle();
        check_value("out_grant.zone", out_grant.zone, 8'h07);
        serve_one();
        idle();
        check_value("out_valid", out_valid, 0);

        // Random mix, small zone range so cancels hit often
        threshold = 8'd20;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rnd_req.zone = ZONE_W'($urandom_range(0, 7));
            rnd_req.pri  = PRI_W'($urandom_range(0, 3));
            apply_inputs($urandom_range(0, 1) == 1, rnd_req, $urandom_range(0, 15) == 0,
                         ZONE_W'($urandom_range(0, 7)), $urandom_range(0, 2) == 0);
        end
        drain_queue();
        repeat (2) idle();

        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verif
source/pq_pkg.sv
source/request_slot.sv
source/slot_arbiter.sv
source/queue_ctrl.sv
source/pq_top.sv
verif/tb_pq_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the request queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pq_top \
    -f verilog.f -o tb_pq_top > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_pq_top > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
